// ==== rtl/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// DRAM side
`define CONV_ADDR_W      32
`define CONV_BYTE_W      8
`define CONV_BURST_LEN   8   // Beats per burst and the address step

// Read latency from strobe to first beat
`define CONV_RD_LATENCY  4

// Kernel and window length of two bursts each
`define CONV_TAPS        16

// Width of the count of 8-window groups per run
`define CONV_GROUP_W     8

// Wide enough for 16 products of two signed bytes
`define CONV_ACC_W       20

`endif

// ==== rtl/conv_pkg.sv ====
`include "conv_cfg.svh"

package conv_pkg;

    typedef struct packed {
        logic [`CONV_ADDR_W-1:0]  src_base;
        logic [`CONV_ADDR_W-1:0]  dst_base;
        logic [`CONV_GROUP_W-1:0] num_groups;  // Run covers 8 windows per group
    } cfg_t;

    typedef struct packed {
        logic                     we;
        logic [1:0]               sel;         // 0 src, 1 dst, 2 groups
        logic [`CONV_ADDR_W-1:0]  wdata;
    } cfg_wr_t;

    typedef struct packed {
        logic                     stb;
        logic [`CONV_ADDR_W-1:0]  addr;
    } rd_req_t;

    typedef struct packed {
        logic                     cmd_stb;
        logic [`CONV_ADDR_W-1:0]  addr;
        logic                     beat_stb;
        logic [`CONV_BYTE_W-1:0]  data;
    } wr_req_t;

    typedef enum logic [1:0] {
        BEAT_NONE,
        BEAT_KERNEL,
        BEAT_DATA
    } beat_kind_e;

    typedef struct packed {
        beat_kind_e               kind;
        logic signed [`CONV_BYTE_W-1:0] data;
    } byte_beat_t;

    typedef struct packed {
        logic                     valid;
        logic signed [`CONV_BYTE_W-1:0] data;
    } mac_result_t;

endpackage

// ==== rtl/conv_regs.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_regs
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  cfg_wr_t i_cfg,
    input  logic    i_busy,
    output cfg_t    o_cfg
);

    cfg_t cfg_q;

    // Writes only land between runs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_q <= '0;
        end else if (i_cfg.we && !i_busy) begin
            case (i_cfg.sel)
                2'd0: begin
                    cfg_q.src_base <= i_cfg.wdata;
                end
                2'd1: begin
                    cfg_q.dst_base <= i_cfg.wdata;
                end
                2'd2: begin
                    cfg_q.num_groups <= i_cfg.wdata[`CONV_GROUP_W-1:0];
                end
                default: begin
                    cfg_q <= cfg_q;  // Sel 3 unused
                end
            endcase
        end
    end

    assign o_cfg = cfg_q;

    // A run with no groups would never signal done
    a_groups_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(i_busy) |-> (o_cfg.num_groups != '0)
    );

endmodule

// ==== rtl/dram_reader.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module dram_reader
    import conv_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_start,
    input  cfg_t                    i_cfg,
    input  logic [`CONV_BYTE_W-1:0] i_rd_data,
    input  logic                    i_done,
    output logic                    o_ready,
    output logic                    o_busy,
    output rd_req_t                 o_rd,
    output byte_beat_t              o_beat
);

    logic                           busy;
    logic                           in_burst;   // One burst outstanding
    logic                           rd_stb;
    logic [3:0]                     cnt;        // Cycles since the strobe
    logic [`CONV_GROUP_W+3:0]       burst_idx;
    logic [`CONV_GROUP_W+3:0]       total_bursts;
    logic [`CONV_ADDR_W-1:0]        rd_addr;
    logic                           start_ok;
    logic                           beat_vld;
    logic                           last_beat;
    logic                           more;
    beat_kind_e                     beat_kind;
    logic signed [`CONV_BYTE_W-1:0] beat_data;

    assign start_ok  = i_start && !busy;
    // Two kernel bursts, then 16 data bursts per group
    assign total_bursts = {i_cfg.num_groups, 4'b0000} + (`CONV_TAPS / `CONV_BURST_LEN);
    assign beat_vld  = in_burst && (cnt >= `CONV_RD_LATENCY);
    assign last_beat = in_burst && (cnt == `CONV_RD_LATENCY + `CONV_BURST_LEN - 1);
    assign more      = (burst_idx + 1'b1) < total_bursts;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            in_burst  <= 1'b0;
            rd_stb    <= 1'b0;
            cnt       <= '0;
            burst_idx <= '0;
            beat_kind <= BEAT_NONE;
        end else begin
            if (start_ok) begin
                busy      <= 1'b1;
                in_burst  <= 1'b1;
                rd_stb    <= 1'b1;
                cnt       <= '0;
                burst_idx <= '0;
            end else begin
                rd_stb <= 1'b0;
                if (last_beat) begin
                    cnt <= '0;
                    if (more) begin
                        burst_idx <= burst_idx + 1'b1;
                        rd_stb    <= 1'b1;  // Back to back with the last beat
                    end else begin
                        in_burst <= 1'b0;
                    end
                end else if (in_burst) begin
                    cnt <= cnt + 1'b1;
                end
                if (i_done) begin
                    busy <= 1'b0;
                end
            end

            if (!beat_vld) begin
                beat_kind <= BEAT_NONE;
            end else if (burst_idx < (`CONV_TAPS / `CONV_BURST_LEN)) begin
                beat_kind <= BEAT_KERNEL;
            end else begin
                beat_kind <= BEAT_DATA;
            end
        end
    end

    always_ff @(posedge clk) begin
        beat_data <= i_rd_data;
        if (start_ok) begin
            rd_addr <= i_cfg.src_base;
        end else if (last_beat && more) begin
            rd_addr <= rd_addr + `CONV_BURST_LEN;
        end
    end

    assign o_busy  = busy;
    assign o_ready = !busy;
    assign o_rd    = '{stb: rd_stb, addr: rd_addr};
    assign o_beat  = '{kind: beat_kind, data: beat_data};

    // DRAM port takes a single outstanding burst
    a_one_burst: assert property (
        @(posedge clk) disable iff (!rst_n)
        o_rd.stb |=> (!o_rd.stb) [*(`CONV_RD_LATENCY + `CONV_BURST_LEN - 1)]
    );

endmodule

// ==== rtl/window_mac.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module window_mac
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  byte_beat_t  i_beat,
    output mac_result_t o_result
);

    logic signed [`CONV_BYTE_W-1:0]   kern    [`CONV_TAPS];
    logic signed [`CONV_BYTE_W-1:0]   win     [`CONV_TAPS];
    logic signed [`CONV_BYTE_W-1:0]   win_nxt [`CONV_TAPS];
    logic [3:0]                       data_cnt;
    logic                             launch;

    logic signed [`CONV_BYTE_W+3:0]   pp1     [`CONV_TAPS];  // Low nibble times kernel
    logic signed [`CONV_BYTE_W-5:0]   hi1     [`CONV_TAPS];
    logic signed [`CONV_BYTE_W-1:0]   k1      [`CONV_TAPS];
    logic signed [2*`CONV_BYTE_W-1:0] prod2   [`CONV_TAPS];
    logic signed [`CONV_ACC_W-1:0]    row3    [4];
    logic signed [`CONV_ACC_W-1:0]    sum4;
    logic signed [`CONV_BYTE_W-1:0]   sat;
    logic                             v1;
    logic                             v2;
    logic                             v3;
    logic                             v4;

    // Window as it will be after this beat
    always_comb begin
        for (int i = 0; i < `CONV_TAPS - 1; i++) begin
            win_nxt[i] = win[i+1];
        end
        win_nxt[`CONV_TAPS-1] = i_beat.data;
    end

    assign launch = (i_beat.kind == BEAT_DATA) && (&data_cnt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                kern[i] <= '0;
                win[i]  <= '0;
            end
            data_cnt <= '0;
            v1 <= 1'b0;
            v2 <= 1'b0;
            v3 <= 1'b0;
            v4 <= 1'b0;
        end else begin
            if (i_beat.kind == BEAT_KERNEL) begin
                for (int i = 0; i < `CONV_TAPS - 1; i++) begin
                    kern[i] <= kern[i+1];
                end
                kern[`CONV_TAPS-1] <= i_beat.data;
            end
            if (i_beat.kind == BEAT_DATA) begin
                win      <= win_nxt;
                data_cnt <= data_cnt + 1'b1;  // Wraps at end of window
            end
            v1 <= launch;
            v2 <= v1;
            v3 <= v2;
            v4 <= v3;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                pp1[i] <= $signed({1'b0, win_nxt[i][3:0]}) * kern[i];
                hi1[i] <= win_nxt[i][`CONV_BYTE_W-1:4];
                k1[i]  <= kern[i];
            end
        end
        if (v1) begin
            for (int i = 0; i < `CONV_TAPS; i++) begin
                prod2[i] <= pp1[i] + ((hi1[i] * k1[i]) <<< 4);
            end
        end
        if (v2) begin
            for (int r = 0; r < 4; r++) begin
                row3[r] <= (prod2[4*r] + prod2[4*r+1]) + (prod2[4*r+2] + prod2[4*r+3]);
            end
        end
        if (v3) begin
            sum4 <= (row3[0] + row3[1]) + (row3[2] + row3[3]);
        end
    end

    // Clamp to a signed byte
    always_comb begin
        if (sum4 > 127) begin
            sat = 8'sd127;
        end else if (sum4 < -128) begin
            sat = -8'sd128;
        end else begin
            sat = sum4[`CONV_BYTE_W-1:0];
        end
    end

    assign o_result = '{valid: v4, data: sat};

    // Kernel bursts only come before the first window
    a_kernel_between_windows: assert property (
        @(posedge clk) disable iff (!rst_n)
        (i_beat.kind == BEAT_KERNEL) |-> (data_cnt == '0)
    );

endmodule

// ==== rtl/dram_writer.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module dram_writer
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  cfg_t        i_cfg,
    input  mac_result_t i_result,
    output wr_req_t     o_wr,
    output logic        o_done
);

    logic signed [`CONV_BYTE_W-1:0] col_buf [`CONV_BURST_LEN];
    logic signed [`CONV_BYTE_W-1:0] out_sr  [`CONV_BURST_LEN];
    logic [2:0]                     res_cnt;
    logic [2:0]                     beat_idx;
    logic [`CONV_GROUP_W-1:0]       grp;
    logic [`CONV_ADDR_W-1:0]        wr_addr;
    logic                           cmd_stb;
    logic                           beat_stb;
    logic                           last_grp;
    logic                           done_q;
    logic                           group_full;
    logic                           is_last_grp;

    assign group_full  = i_result.valid && (&res_cnt);
    assign is_last_grp = (grp == i_cfg.num_groups - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_stb  <= 1'b0;
            beat_stb <= 1'b0;
            done_q   <= 1'b0;
            res_cnt  <= '0;
            beat_idx <= '0;
            grp      <= '0;
            last_grp <= 1'b0;
        end else begin
            cmd_stb  <= group_full;
            beat_stb <= cmd_stb || (beat_stb && !(&beat_idx));
            done_q   <= beat_stb && (&beat_idx) && last_grp;  // After final beat
            if (i_result.valid) begin
                res_cnt <= res_cnt + 1'b1;
            end
            if (beat_stb) begin
                beat_idx <= beat_idx + 1'b1;
            end
            if (group_full) begin
                last_grp <= is_last_grp;
                grp      <= is_last_grp ? '0 : grp + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_result.valid) begin
            col_buf[res_cnt] <= i_result.data;
        end
        if (group_full) begin
            for (int i = 0; i < `CONV_BURST_LEN - 1; i++) begin
                out_sr[i] <= col_buf[i];
            end
            out_sr[`CONV_BURST_LEN-1] <= i_result.data;
            wr_addr <= i_cfg.dst_base + {{(`CONV_ADDR_W-`CONV_GROUP_W-3){1'b0}}, grp, 3'b000};
        end else if (beat_stb) begin
            for (int i = 0; i < `CONV_BURST_LEN - 1; i++) begin
                out_sr[i] <= out_sr[i+1];
            end
        end
    end

    assign o_wr   = '{cmd_stb: cmd_stb, addr: wr_addr, beat_stb: beat_stb, data: out_sr[0]};
    assign o_done = done_q;

    // Burst must drain before the next result shows up
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        i_result.valid |-> !(cmd_stb || beat_stb)
    );

endmodule

// ==== rtl/conv_top.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  conv_pkg::cfg_wr_t       i_cfg,
    input  logic                    i_start,
    output logic                    o_ready,
    output conv_pkg::rd_req_t       o_rd,
    input  logic [`CONV_BYTE_W-1:0] i_rd_data,
    output conv_pkg::wr_req_t       o_wr
);

    conv_pkg::cfg_t        cfg;
    logic                  busy;
    logic                  done;
    conv_pkg::byte_beat_t  beat;
    conv_pkg::mac_result_t result;

    conv_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cfg     (i_cfg),
        .i_busy    (busy),
        .o_cfg     (cfg)
    );

    dram_reader u_reader (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_start   (i_start),
        .i_cfg     (cfg),
        .i_rd_data (i_rd_data),
        .i_done    (done),
        .o_ready   (o_ready),
        .o_busy    (busy),
        .o_rd      (o_rd),
        .o_beat    (beat)
    );

    window_mac u_mac (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_beat    (beat),
        .o_result  (result)
    );

    dram_writer u_writer (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cfg     (cfg),
        .i_result  (result),
        .o_wr      (o_wr),
        .o_done    (done)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;  // 10 ns period
        end
    end

    // Held low over three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== bench/conv_checker.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_checker
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  cfg_wr_t i_cfg,
    input  logic    i_start,
    input  logic    i_ready,
    input  rd_req_t i_rd,
    input  wr_req_t i_wr,
    output int      o_value_errs,
    output int      o_proto_errs,
    output int      o_checked
);

    localparam int MEM_MASK = 'hfff;

    cfg_t shadow;      // Mirror of the config registers
    cfg_t run_cfg;     // Config latched at start
    logic run_active;
    int   groups;
    int   rd_bursts;
    int   wr_bursts;
    int   beats_left;
    int   res_idx;
    int   idle_wait;

    initial begin
        o_value_errs = 0;
        o_proto_errs = 0;
        o_checked    = 0;
    end

    function automatic int mem_byte(input logic [31:0] addr);
        return $signed(conv_tb.mem[addr & MEM_MASK]);
    endfunction

    // Clamped dot product of the kernel with window win
    function automatic logic [7:0] expected_result(input logic [31:0] src, input int win);
        int acc;
        acc = 0;
        for (int n = 0; n < `CONV_TAPS; n++) begin
            acc += mem_byte(src + n) * mem_byte(src + `CONV_TAPS * (win + 1) + n);
        end
        if (acc > 127) begin
            return 8'h7f;
        end else if (acc < -128) begin
            return 8'h80;
        end
        return acc[7:0];
    endfunction

    task automatic protocol_error(input string what);
        o_proto_errs++;
        $display("At %0t ns: %s", $time, what);
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            o_value_errs++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            shadow     = '0;
            run_active = 1'b0;
            beats_left = 0;
        end else begin
            if (!run_active) begin
                if (!i_ready) protocol_error("o_ready is low with no run in progress");
                if (i_rd.stb) protocol_error("read strobe with no run in progress");
                if (i_wr.cmd_stb || i_wr.beat_stb) begin
                    protocol_error("write strobe with no run in progress");
                end
            end else begin
                if (i_rd.stb) begin
                    if (rd_bursts >= 2 + 16 * groups) begin
                        protocol_error("extra read burst beyond the end of the run");
                    end
                    compare("o_rd.addr", run_cfg.src_base + 8 * rd_bursts, i_rd.addr);
                    rd_bursts++;
                end
                if (i_wr.cmd_stb) begin
                    if (beats_left != 0) protocol_error("write command inside a burst");
                    if (wr_bursts >= groups) protocol_error("extra write burst");
                    compare("o_wr.addr", run_cfg.dst_base + 8 * wr_bursts, i_wr.addr);
                    wr_bursts++;
                    beats_left = 8;
                end else if (i_wr.beat_stb) begin
                    if (beats_left == 0) begin
                        protocol_error("write beat without a write command");
                    end else begin
                        compare("o_wr.data", expected_result(run_cfg.src_base, res_idx),
                                i_wr.data);
                        res_idx++;
                        beats_left--;
                        o_checked++;
                    end
                end
                if (i_ready) begin
                    if (rd_bursts != 2 + 16 * groups) begin
                        protocol_error($sformatf("run ended after %0d of %0d read bursts",
                                                 rd_bursts, 2 + 16 * groups));
                    end
                    if (wr_bursts != groups || beats_left != 0) begin
                        protocol_error($sformatf("run ended after %0d of %0d write bursts",
                                                 wr_bursts, groups));
                    end
                    run_active = 1'b0;
                end else if (res_idx == 8 * groups && beats_left == 0) begin
                    idle_wait++;
                    if (idle_wait == 8) begin
                        protocol_error("o_ready did not return after the last write beat");
                    end
                end
            end
            if (i_start && i_ready) begin
                run_active = 1'b1;
                run_cfg    = shadow;
                groups     = int'(shadow.num_groups);
                rd_bursts  = 0;
                wr_bursts  = 0;
                beats_left = 0;
                res_idx    = 0;
                idle_wait  = 0;
            end
            if (i_cfg.we && i_ready) begin  // Writes while busy are dropped
                case (i_cfg.sel)
                    2'd0: shadow.src_base = i_cfg.wdata;
                    2'd1: shadow.dst_base = i_cfg.wdata;
                    2'd2: shadow.num_groups = i_cfg.wdata[`CONV_GROUP_W-1:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== bench/conv_tb.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_tb
    import conv_pkg::*;
();

    localparam int MEM_AW        = 12;
    localparam int TOTAL_BURSTS  = (2 + 16 * 1) + (2 + 16 * 1) + (2 + 16 * 3) + (2 + 16 * 2);
    localparam int CYCLE_LIMIT   = TOTAL_BURSTS * (`CONV_RD_LATENCY + 9) * 3 / 2 + 200;
    localparam int TOTAL_RESULTS = 8 * (1 + 1 + 3 + 2);

    logic        clk;
    logic        rst_n;
    cfg_wr_t     cfg_in;
    logic        start;
    logic        ready;
    rd_req_t     rd;
    logic [7:0]  rd_data;
    wr_req_t     wr;
    logic [7:0]  mem [0:(1 << MEM_AW) - 1];
    int          value_errs;
    int          proto_errs;
    int          checked;
    int          tb_errs = 0;
    int          cycles = 0;
    logic [31:0] rd_base;
    int          rd_age = 0;
    logic        rd_busy = 1'b0;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    conv_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_cfg     (cfg_in),
        .i_start   (start),
        .o_ready   (ready),
        .o_rd      (rd),
        .i_rd_data (rd_data),
        .o_wr      (wr)
    );

    conv_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cfg        (cfg_in),
        .i_start      (start),
        .i_ready      (ready),
        .i_rd         (rd),
        .i_wr         (wr),
        .o_value_errs (value_errs),
        .o_proto_errs (proto_errs),
        .o_checked    (checked)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Kernel of +127, then windows of +127, -128, alternating, and +1
    function automatic logic [7:0] sat_byte(input int off);
        int n;
        n = off % `CONV_TAPS;
        if (off < `CONV_TAPS) begin
            return 8'h7f;
        end
        case (((off - `CONV_TAPS) / `CONV_TAPS) % 4)
            0: return 8'h7f;
            1: return 8'h80;
            2: return n[0] ? 8'h80 : 8'h7f;
            default: return 8'h01;
        endcase
    endfunction

    task automatic fill_memory();
        logic [31:0] seed;
        seed = 32'h7718_b926;
        for (int a = 0; a < (1 << MEM_AW); a++) begin
            seed = xorshift32(seed);
            mem[a] = seed[7:0];
        end
        for (int a = 'h100; a < 'h190; a++) begin
            mem[a] = sat_byte(a - 'h100);
        end
        // Small kernel and 7-bit data keep many sums of the three-group run unclamped
        for (int a = 'h200; a < 'h390; a++) begin
            if (a < 'h210) begin
                mem[a] = {{6{mem[a][1]}}, mem[a][1:0]};
            end else begin
                mem[a] = {mem[a][6], mem[a][6:0]};
            end
        end
    endtask

    task automatic write_cfg(input logic [1:0] sel, input logic [31:0] data);
        cfg_in = '{we: 1'b1, sel: sel, wdata: data};
        @(posedge clk);
        #1;
        cfg_in.we = 1'b0;
    endtask

    task automatic configure(input logic [31:0] src, input logic [31:0] dst, input int grp);
        write_cfg(2'd0, src);
        write_cfg(2'd1, dst);
        write_cfg(2'd2, grp);
    endtask

    task automatic start_run();
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_ready();
        while (!ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic end_run(input bit timed_out);
        $display("Errors: %0d value, %0d protocol, %0d other; %0d results checked",
                 value_errs, proto_errs, tb_errs, checked);
        if (!timed_out && value_errs + proto_errs + tb_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // DRAM read port gives 8 beats starting CONV_RD_LATENCY cycles after the strobe
    always @(posedge clk) begin : dram_read
        logic        stb_s;
        logic [31:0] addr_s;
        stb_s  = rd.stb;
        addr_s = rd.addr;
        #1;
        if (stb_s) begin
            rd_busy = 1'b1;
            rd_age  = 1;
            rd_base = addr_s;
        end else if (rd_busy) begin
            rd_age++;
        end
        if (rd_busy && rd_age >= `CONV_RD_LATENCY && rd_age < `CONV_RD_LATENCY + 8) begin
            rd_data = mem[(rd_base + rd_age - `CONV_RD_LATENCY) & ((1 << MEM_AW) - 1)];
        end else begin
            rd_data = 8'h00;
        end
        if (rd_age >= `CONV_RD_LATENCY + 8) begin
            rd_busy = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            end_run(1'b1);
        end
    end

    initial begin
        cfg_in  = '0;
        start   = 1'b0;
        rd_data = 8'h00;
        fill_memory();
        @(posedge rst_n);
        idle_cycles(20);                       // Nothing may move before start
        configure(32'h0000_0000, 32'h0000_0800, 1);
        start_run();
        wait_ready();
        configure(32'h0000_0100, 32'h0000_0840, 1);  // Saturating windows
        start_run();
        wait_ready();
        configure(32'h0000_0200, 32'h0000_0900, 3);
        start_run();
        wait_ready();
        configure(32'h0000_0400, 32'h0000_0a00, 2);
        start_run();
        idle_cycles(40);
        write_cfg(2'd1, 32'h0000_0b00);        // Dropped while busy
        start_run();
        wait_ready();
        idle_cycles(10);
        if (checked != TOTAL_RESULTS) begin
            tb_errs++;
            $display("Only %0d of %0d results were written", checked, TOTAL_RESULTS);
        end
        end_run(1'b0);
    end

endmodule

// ==== build.f ====
+incdir+rtl
rtl/conv_pkg.sv
rtl/conv_regs.sv
rtl/dram_reader.sv
rtl/window_mac.sv
rtl/dram_writer.sv
rtl/conv_top.sv
bench/tb_clk_gen.sv
bench/conv_checker.sv
bench/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv_engine

export_include_dirs:
  - rtl

sources:
  - rtl/conv_pkg.sv
  - rtl/conv_regs.sv
  - rtl/dram_reader.sv
  - rtl/window_mac.sv
  - rtl/dram_writer.sv
  - rtl/conv_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/conv_checker.sv
      - bench/conv_tb.sv
